/* source/ooo_settings.svh */
// widths, depths and unit indices for the dispatch stage
// ROB_SIZE must stay a power of two that matches ROB_TAG_LEN,
// since the ROB pointers wrap by overflow
`ifndef OOO_SETTINGS_SVH
`define OOO_SETTINGS_SVH

// datapath and register file
`define XLEN          32
`define REG_NUM       32
`define REG_ADDR_LEN  5

// reorder buffer
`define ROB_SIZE      8
`define ROB_TAG_LEN   3

// reservation stations, one per unit
`define FU_NUM        4
`define FU_ALU        2'd0
`define FU_LSU        2'd1
`define FU_MULT       2'd2
`define FU_BTU        2'd3

// operand states in the map table
// value sits in the register file
`define STAT_REGFILE  2'b00
// waiting on a tag
`define STAT_PENDING  2'b01
// produced, not yet retired
`define STAT_IN_ROB   2'b11

`endif

/* source/ooo_pkg.sv */
// shared vector types of the dispatch stage
// widths come from the settings header
`include "ooo_settings.svh"

package ooo_pkg;

    // one operand or result word
    typedef logic [`XLEN-1:0] data_t;

    // architectural register number
    typedef logic [`REG_ADDR_LEN-1:0] reg_addr_t;

    // reorder buffer slot, also the rename tag
    typedef logic [`ROB_TAG_LEN-1:0] rob_tag_t;

    // functional unit index, selects the station
    typedef logic [1:0] fu_sel_t;

    // operand state, see STAT_* encodings
    typedef logic [1:0] data_stat_t;

    // alu function code
    typedef logic [3:0] func_t;

    // raw func3 field of the instruction
    typedef logic [2:0] func3_t;

endpackage

/* source/ooo_ifs.sv */
// internal buses of the dispatch stage
// all answers on rename_if and rob_if are combinational,
// commit_if carries single-cycle pulses

////////////////////////////////////////
// rename lookup and tag assignment
////////////////////////////////////////
interface rename_if;
    ooo_pkg::reg_addr_t  src1_addr;
    ooo_pkg::reg_addr_t  src2_addr;
    ooo_pkg::reg_addr_t  dest_addr;
    logic                assign_valid;
    ooo_pkg::rob_tag_t   assign_tag;
    ooo_pkg::data_stat_t src1_stat;
    ooo_pkg::rob_tag_t   src1_tag;
    ooo_pkg::data_stat_t src2_stat;
    ooo_pkg::rob_tag_t   src2_tag;

    modport requester (
        output src1_addr, src2_addr, dest_addr, assign_valid, assign_tag,
        input  src1_stat, src1_tag, src2_stat, src2_tag
    );
    modport lookup (
        input  src1_addr, src2_addr, dest_addr, assign_valid, assign_tag,
        output src1_stat, src1_tag, src2_stat, src2_tag
    );
endinterface

////////////////////////////////////////
// rob allocation and value reads
////////////////////////////////////////
interface rob_if;
    ooo_pkg::rob_tag_t  tail_tag;
    logic               full;
    logic               alloc;
    ooo_pkg::reg_addr_t alloc_dest;
    ooo_pkg::data_t     alloc_pc;
    ooo_pkg::func_t     alloc_func;
    ooo_pkg::rob_tag_t  rd1_tag;
    ooo_pkg::data_t     rd1_value;
    ooo_pkg::rob_tag_t  rd2_tag;
    ooo_pkg::data_t     rd2_value;

    modport allocator (
        input  tail_tag, full, rd1_value, rd2_value,
        output alloc, alloc_dest, alloc_pc, alloc_func, rd1_tag, rd2_tag
    );
    modport buffer (
        output tail_tag, full, rd1_value, rd2_value,
        input  alloc, alloc_dest, alloc_pc, alloc_func, rd1_tag, rd2_tag
    );
endinterface

////////////////////////////////////////
// in-order retirement
////////////////////////////////////////
interface commit_if;
    logic               valid;
    ooo_pkg::reg_addr_t reg_addr;
    ooo_pkg::rob_tag_t  tag;
    ooo_pkg::data_t     value;

    modport source (output valid, reg_addr, tag, value);
    modport sink   (input  valid, reg_addr, tag, value);
endinterface

/* source/map_table.sv */
// register renaming table with per-register operand state
// lookups show state from before the edge; x0 is never renamed
// per register, rename beats cdb promotion beats commit clear
`include "ooo_settings.svh"

module map_table (
    input  logic              clk,
    input  logic              rst_n,
    rename_if.lookup          ren,
    commit_if.sink            cmt,
    input  logic              cdb_valid,
    input  ooo_pkg::rob_tag_t cdb_tag
);

    // producer tag and state of each register
    ooo_pkg::rob_tag_t   tag_q  [`REG_NUM];
    ooo_pkg::data_stat_t stat_q [`REG_NUM];

    ////////////////////////////////////////
    // lookups
    ////////////////////////////////////////

    // x0 keeps STAT_REGFILE from reset on, so no special case here
    assign ren.src1_stat = stat_q[ren.src1_addr];
    assign ren.src1_tag  = tag_q[ren.src1_addr];
    assign ren.src2_stat = stat_q[ren.src2_addr];
    assign ren.src2_tag  = tag_q[ren.src2_addr];

    ////////////////////////////////////////
    // state update
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                tag_q[i]  <= '0;
                stat_q[i] <= `STAT_REGFILE;
            end
        end else begin
            // entry 0 is skipped, x0 stays in the regfile
            for (int i = 1; i < `REG_NUM; i++) begin
                if (ren.assign_valid && ren.dest_addr == ooo_pkg::reg_addr_t'(i)) begin
                    // new producer, wins over a same-cycle commit
                    tag_q[i]  <= ren.assign_tag;
                    stat_q[i] <= `STAT_PENDING;
                end else if (cdb_valid && stat_q[i] == `STAT_PENDING
                             && tag_q[i] == cdb_tag) begin
                    // result broadcast, value now lives in the rob
                    stat_q[i] <= `STAT_IN_ROB;
                end else if (cmt.valid && stat_q[i] != `STAT_REGFILE
                             && tag_q[i] == cmt.tag) begin
                    // retired by the same producer, back to the regfile
                    // a newer rename has a different tag and is left alone
                    stat_q[i] <= `STAT_REGFILE;
                end
            end
        end
    end

endmodule

/* source/reorder_buffer.sv */
// circular reorder buffer, ROB_SIZE entries, one retire per cycle
// alloc is ignored while full, even if the head retires that cycle
// cdb writes must target an allocated, incomplete tag
`include "ooo_settings.svh"

module reorder_buffer (
    input  logic              clk,
    input  logic              rst_n,
    rob_if.buffer             rob,
    commit_if.source          cmt,
    input  logic              cdb_valid,
    input  ooo_pkg::rob_tag_t cdb_tag,
    input  ooo_pkg::data_t    cdb_value
);

    // entry payload
    ooo_pkg::reg_addr_t dest_q  [`ROB_SIZE];
    ooo_pkg::data_t     value_q [`ROB_SIZE];

    // entry control
    logic [`ROB_SIZE-1:0] complete_q;

    // pointers wrap by overflow
    ooo_pkg::rob_tag_t      head_q;
    ooo_pkg::rob_tag_t      tail_q;
    logic [`ROB_TAG_LEN:0]  count_q;

    logic do_alloc;
    logic do_retire;

    ////////////////////////////////////////
    // status and reads
    ////////////////////////////////////////

    assign rob.full     = (count_q == (`ROB_TAG_LEN+1)'(`ROB_SIZE));
    assign rob.tail_tag = tail_q;

    // operand reads for the dispatcher
    assign rob.rd1_value = value_q[rob.rd1_tag];
    assign rob.rd2_value = value_q[rob.rd2_tag];

    assign do_alloc  = rob.alloc && !rob.full;
    // head retires once it shows complete
    assign do_retire = (count_q != '0) && complete_q[head_q];

    assign cmt.valid    = do_retire;
    assign cmt.reg_addr = dest_q[head_q];
    assign cmt.tag      = head_q;
    assign cmt.value    = value_q[head_q];

    ////////////////////////////////////////
    // destination and result payload
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (do_alloc) begin
            dest_q[tail_q] <= rob.alloc_dest;
        end
        if (cdb_valid) begin
            value_q[cdb_tag] <= cdb_value;
        end
    end

    // pointers, count and complete flags
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head_q     <= '0;
            tail_q     <= '0;
            count_q    <= '0;
            complete_q <= '0;
        end else begin
            if (do_alloc) begin
                // fresh entry starts incomplete
                complete_q[tail_q] <= 1'b0;
                tail_q             <= tail_q + 1'b1;
            end
            if (cdb_valid) begin
                complete_q[cdb_tag] <= 1'b1;
            end
            if (do_retire) begin
                head_q <= head_q + 1'b1;
            end
            case ({do_alloc, do_retire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

/* source/arch_regfile.sv */
// architectural register file, two async reads, one commit write
// reads show state from before the edge, no write-through
`include "ooo_settings.svh"

module arch_regfile (
    input  logic               clk,
    input  logic               rst_n,
    input  ooo_pkg::reg_addr_t rd1_addr,
    input  ooo_pkg::reg_addr_t rd2_addr,
    output ooo_pkg::data_t     rd1_data,
    output ooo_pkg::data_t     rd2_data,
    commit_if.sink             cmt
);

    ooo_pkg::data_t regs_q [`REG_NUM];

    // x0 reads zero whatever is stored
    assign rd1_data = (rd1_addr == '0) ? '0 : regs_q[rd1_addr];
    assign rd2_data = (rd2_addr == '0) ? '0 : regs_q[rd2_addr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regs_q[i] <= '0;
            end
        end else if (cmt.valid && cmt.reg_addr != '0) begin
            // retired result
            regs_q[cmt.reg_addr] <= cmt.value;
        end
    end

endmodule

/* source/dispatcher.sv */
// combinational dispatch: operand select, station steering, stall
// the source holds the instruction while stall is high
// rename and rob allocation happen at the next edge
`include "ooo_settings.svh"

module dispatcher (
    input  logic                  in_valid,
    input  ooo_pkg::fu_sel_t      in_fu,
    input  ooo_pkg::func_t        in_func,
    input  ooo_pkg::func3_t       in_func3,
    input  ooo_pkg::reg_addr_t    in_dest,
    input  ooo_pkg::reg_addr_t    in_src1,
    input  ooo_pkg::reg_addr_t    in_src2,
    input  ooo_pkg::data_t        in_imm,
    input  ooo_pkg::data_t        in_pc,
    input  ooo_pkg::data_t        in_npc,
    input  logic                  in_imm_valid,
    input  logic                  in_pc_valid,
    input  logic [`FU_NUM-1:0]    rs_full,
    input  logic                  cdb_valid,
    input  ooo_pkg::rob_tag_t     cdb_tag,
    input  ooo_pkg::data_t        cdb_value,
    output ooo_pkg::reg_addr_t    rf_rd1_addr,
    output ooo_pkg::reg_addr_t    rf_rd2_addr,
    input  ooo_pkg::data_t        rf_rd1_data,
    input  ooo_pkg::data_t        rf_rd2_data,
    rename_if.requester           ren,
    rob_if.allocator              rob,
    output logic                  dispatch,
    output logic                  stall,
    output logic [`FU_NUM-1:0]    rs_load,
    output ooo_pkg::rob_tag_t     rs_tag_dest,
    output ooo_pkg::rob_tag_t     rs_tag_src1,
    output ooo_pkg::rob_tag_t     rs_tag_src2,
    output logic                  rs_ready_src1,
    output logic                  rs_ready_src2,
    output ooo_pkg::data_t        rs_value_src1,
    output ooo_pkg::data_t        rs_value_src2,
    output ooo_pkg::data_t        rs_imm,
    output ooo_pkg::data_t        rs_pc,
    output ooo_pkg::data_t        rs_npc,
    output ooo_pkg::func_t        rs_fu_func,
    output ooo_pkg::func3_t       rs_func3
);

    logic is_btu;
    logic pc_over;
    logic imm_over;

    // {ready, value} of one source, first match wins
    function automatic logic [`XLEN:0] pick_operand(
        input logic                override,
        input ooo_pkg::data_t      override_val,
        input ooo_pkg::data_stat_t stat,
        input ooo_pkg::rob_tag_t   tag,
        input ooo_pkg::data_t      rf_val,
        input ooo_pkg::data_t      rob_val
    );
        if (override)
            return {1'b1, override_val};
        if (stat == `STAT_REGFILE)
            return {1'b1, rf_val};
        if (stat == `STAT_IN_ROB)
            return {1'b1, rob_val};
        // same-cycle cdb bypass for a pending producer
        if (stat == `STAT_PENDING && cdb_valid && cdb_tag == tag)
            return {1'b1, cdb_value};
        return {1'b0, `XLEN'(0)};
    endfunction

    ////////////////////////////////////////
    // stall and steering
    ////////////////////////////////////////

    // target station or rob full blocks the instruction
    assign stall    = in_valid && (rs_full[in_fu] || rob.full);
    assign dispatch = in_valid && !stall;
    // one-hot load of the target station
    assign rs_load  = dispatch ? (`FU_NUM'(1) << in_fu) : '0;

    ////////////////////////////////////////
    // rename and rob allocation
    ////////////////////////////////////////

    assign ren.src1_addr    = in_src1;
    assign ren.src2_addr    = in_src2;
    assign ren.dest_addr    = in_dest;
    assign ren.assign_valid = dispatch;
    assign ren.assign_tag   = rob.tail_tag;

    assign rob.alloc      = dispatch;
    assign rob.alloc_dest = in_dest;
    assign rob.alloc_pc   = in_pc;
    assign rob.alloc_func = in_func;
    // rob value reads follow the renamed tags
    assign rob.rd1_tag    = ren.src1_tag;
    assign rob.rd2_tag    = ren.src2_tag;

    assign rf_rd1_addr = in_src1;
    assign rf_rd2_addr = in_src2;

    ////////////////////////////////////////
    // station entry
    ////////////////////////////////////////

    assign is_btu   = (in_fu == `FU_BTU);
    // pc replaces src1 except on branches
    assign pc_over  = in_pc_valid && !is_btu;
    // immediate replaces src2 except on branches and memory ops
    assign imm_over = in_imm_valid && !is_btu && (in_fu != `FU_LSU);

    assign {rs_ready_src1, rs_value_src1} = pick_operand(pc_over, in_pc,
        ren.src1_stat, ren.src1_tag, rf_rd1_data, rob.rd1_value);
    assign {rs_ready_src2, rs_value_src2} = pick_operand(imm_over, in_imm,
        ren.src2_stat, ren.src2_tag, rf_rd2_data, rob.rd2_value);

    assign rs_tag_dest = rob.tail_tag;
    assign rs_tag_src1 = ren.src1_tag;
    assign rs_tag_src2 = ren.src2_tag;
    assign rs_imm      = in_imm;
    // only the branch unit needs pc and npc
    assign rs_pc       = is_btu ? in_pc  : '0;
    assign rs_npc      = is_btu ? in_npc : '0;
    assign rs_fu_func  = in_func;
    assign rs_func3    = in_func3;

endmodule

/* source/dispatch_top.sv */
// dispatch stage top, plain ports only
// stations and units are external and report back through the cdb
`include "ooo_settings.svh"

module dispatch_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    input  ooo_pkg::fu_sel_t   in_fu,
    input  ooo_pkg::func_t     in_func,
    input  ooo_pkg::func3_t    in_func3,
    input  ooo_pkg::reg_addr_t in_dest,
    input  ooo_pkg::reg_addr_t in_src1,
    input  ooo_pkg::reg_addr_t in_src2,
    input  ooo_pkg::data_t     in_imm,
    input  ooo_pkg::data_t     in_pc,
    input  ooo_pkg::data_t     in_npc,
    input  logic               in_imm_valid,
    input  logic               in_pc_valid,
    input  logic [`FU_NUM-1:0] rs_full,
    input  logic               cdb_valid,
    input  ooo_pkg::rob_tag_t  cdb_tag,
    input  ooo_pkg::data_t     cdb_value,
    output logic               dispatch,
    output logic               stall,
    output logic [`FU_NUM-1:0] rs_load,
    output ooo_pkg::rob_tag_t  rs_tag_dest,
    output ooo_pkg::rob_tag_t  rs_tag_src1,
    output ooo_pkg::rob_tag_t  rs_tag_src2,
    output logic               rs_ready_src1,
    output logic               rs_ready_src2,
    output ooo_pkg::data_t     rs_value_src1,
    output ooo_pkg::data_t     rs_value_src2,
    output ooo_pkg::data_t     rs_imm,
    output ooo_pkg::data_t     rs_pc,
    output ooo_pkg::data_t     rs_npc,
    output ooo_pkg::func_t     rs_fu_func,
    output ooo_pkg::func3_t    rs_func3,
    output logic               commit_valid,
    output ooo_pkg::reg_addr_t commit_reg,
    output ooo_pkg::data_t     commit_value
);

    rename_if ren_bus ();
    rob_if    rob_bus ();
    commit_if cmt_bus ();

    ooo_pkg::reg_addr_t rf_rd1_addr;
    ooo_pkg::reg_addr_t rf_rd2_addr;
    ooo_pkg::data_t     rf_rd1_data;
    ooo_pkg::data_t     rf_rd2_data;

    map_table map_table_inst (
        .clk, .rst_n, .ren(ren_bus), .cmt(cmt_bus), .cdb_valid, .cdb_tag
    );

    reorder_buffer reorder_buffer_inst (
        .clk, .rst_n, .rob(rob_bus), .cmt(cmt_bus), .cdb_valid, .cdb_tag, .cdb_value
    );

    arch_regfile arch_regfile_inst (
        .clk, .rst_n,
        .rd1_addr(rf_rd1_addr), .rd2_addr(rf_rd2_addr),
        .rd1_data(rf_rd1_data), .rd2_data(rf_rd2_data),
        .cmt(cmt_bus)
    );

    // name matches cover the in_*, rs_* and cdb ports
    dispatcher dispatcher_inst (
        .ren(ren_bus), .rob(rob_bus), .*
    );

    // retirement seen from outside
    assign commit_valid = cmt_bus.valid;
    assign commit_reg   = cmt_bus.reg_addr;
    assign commit_value = cmt_bus.value;

endmodule

/* tb/dispatch_sva.sv */
// protocol assertions for dispatch_top, attached by bind
// rob occupancy is tracked here from dispatch and commit pulses
`include "ooo_settings.svh"

module dispatch_sva (
    input logic               clk,
    input logic               rst_n,
    input logic               dispatch,
    input logic               stall,
    input logic               commit_valid,
    input logic [`FU_NUM-1:0] rs_load
);
    timeunit 1ns;
    timeprecision 100ps;

    // entries allocated and not yet retired
    logic [`ROB_TAG_LEN:0] outstanding;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            outstanding <= '0;
        end else begin
            case ({dispatch, commit_valid})
                2'b10:   outstanding <= outstanding + 1'b1;
                2'b01:   outstanding <= outstanding - 1'b1;
                default: outstanding <= outstanding;
            endcase
        end
    end

    ////////////////////////////////////////
    // station load and stall
    ////////////////////////////////////////

    onehot_load: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(rs_load))
        else $error("rs_load drives more than one station");

    dispatch_no_stall: assert property (@(posedge clk) disable iff (!rst_n)
        dispatch |-> !stall)
        else $error("dispatch and stall are high together");

    // retirement needs an allocated entry
    commit_needs_entry: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid |-> (outstanding != '0))
        else $error("commit_valid high while the ROB is empty");

endmodule

bind dispatch_top dispatch_sva dispatch_sva_inst (
    .clk(clk),
    .rst_n(rst_n),
    .dispatch(dispatch),
    .stall(stall),
    .commit_valid(commit_valid),
    .rs_load(rs_load)
);

/* tb/dispatch_tb.sv */
// testbench for dispatch_top, random stimulus checked against a cycle model
// the model mirrors register file, map table and rob contents
// the testbench plays the cdb and only completes outstanding, incomplete tags
`include "ooo_settings.svh"

module dispatch_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;
    localparam int SEED         = 32'h1a68e57b;
    localparam int CYC_IDLE     = 4;
    localparam int CYC_STATION  = 60;
    localparam int CYC_ROB      = 24;
    localparam int CYC_DEPEND   = 400;
    localparam int CYC_OVERRIDE = 200;
    localparam int CYC_RANDOM   = 1500;
    localparam int CYC_DRAIN    = 64;
    // all tests plus a margin
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + CYC_IDLE + CYC_STATION + CYC_ROB
        + CYC_DEPEND + CYC_OVERRIDE + CYC_RANDOM + CYC_DRAIN + 200;

    logic               clk = 1'b0;
    logic               rst_n;
    logic               in_valid;
    ooo_pkg::fu_sel_t   in_fu;
    ooo_pkg::func_t     in_func;
    ooo_pkg::func3_t    in_func3;
    ooo_pkg::reg_addr_t in_dest;
    ooo_pkg::reg_addr_t in_src1;
    ooo_pkg::reg_addr_t in_src2;
    ooo_pkg::data_t     in_imm;
    ooo_pkg::data_t     in_pc;
    ooo_pkg::data_t     in_npc;
    logic               in_imm_valid;
    logic               in_pc_valid;
    logic [`FU_NUM-1:0] rs_full;
    logic               cdb_valid;
    ooo_pkg::rob_tag_t  cdb_tag;
    ooo_pkg::data_t     cdb_value;
    logic               dispatch;
    logic               stall;
    logic [`FU_NUM-1:0] rs_load;
    ooo_pkg::rob_tag_t  rs_tag_dest;
    ooo_pkg::rob_tag_t  rs_tag_src1;
    ooo_pkg::rob_tag_t  rs_tag_src2;
    logic               rs_ready_src1;
    logic               rs_ready_src2;
    ooo_pkg::data_t     rs_value_src1;
    ooo_pkg::data_t     rs_value_src2;
    ooo_pkg::data_t     rs_imm;
    ooo_pkg::data_t     rs_pc;
    ooo_pkg::data_t     rs_npc;
    ooo_pkg::func_t     rs_fu_func;
    ooo_pkg::func3_t    rs_func3;
    logic               commit_valid;
    ooo_pkg::reg_addr_t commit_reg;
    ooo_pkg::data_t     commit_value;

    ////////////////////////////////////////
    // model state
    ////////////////////////////////////////

    ooo_pkg::data_t      m_rf   [`REG_NUM];
    ooo_pkg::data_stat_t m_stat [`REG_NUM];
    ooo_pkg::rob_tag_t   m_tag  [`REG_NUM];
    ooo_pkg::reg_addr_t  m_dest [`ROB_SIZE];
    ooo_pkg::data_t      m_val  [`ROB_SIZE];
    logic [`ROB_SIZE-1:0] m_done;
    ooo_pkg::rob_tag_t   m_head;
    ooo_pkg::rob_tag_t   m_tail;
    int                  m_count;
    // instruction stalled last cycle, source keeps it
    logic                held;

    // per test and overall counters
    int t_errors;
    int t_stalls;
    int t_commits;
    int t_bypass;
    int total_errors;
    int total_checks;
    int tests_run;

    dispatch_top dispatch_top_inst (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic bit chance(input int pct);
        return int'($urandom % 100) < pct;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        total_checks++;
        assert (got === exp) else begin
            $display("[FAIL] %0d ns %s: got %h, expected %h", $time, name, got, exp);
            t_errors++;
            total_errors++;
        end
    endtask

    task automatic reset_model();
        for (int r = 0; r < `REG_NUM; r++) begin
            m_rf[r]   = '0;
            m_stat[r] = `STAT_REGFILE;
            m_tag[r]  = '0;
        end
        m_done  = '0;
        m_head  = '0;
        m_tail  = '0;
        m_count = 0;
        held    = 1'b0;
    endtask

    // first source that applies: override, regfile, rob, cdb bypass
    task automatic expect_operand(input logic ovr, input ooo_pkg::data_t ovr_val,
                                  input ooo_pkg::reg_addr_t addr,
                                  output logic rdy, output ooo_pkg::data_t val);
        rdy = 1'b1;
        if (ovr) begin
            val = ovr_val;
        end else if (m_stat[addr] == `STAT_REGFILE) begin
            val = m_rf[addr];
        end else if (m_stat[addr] == `STAT_IN_ROB) begin
            val = m_val[m_tag[addr]];
        end else if (cdb_valid && cdb_tag == m_tag[addr]) begin
            val = cdb_value;
            t_bypass++;
        end else begin
            rdy = 1'b0;
            val = '0;
        end
    endtask

    ////////////////////////////////////////
    // checks of one cycle
    ////////////////////////////////////////

    task automatic check_outputs();
        logic               exp_stall;
        logic               exp_disp;
        logic               exp_retire;
        logic [`FU_NUM-1:0] exp_load;
        logic               rdy1;
        logic               rdy2;
        ooo_pkg::data_t     val1;
        ooo_pkg::data_t     val2;
        logic               is_btu;

        exp_stall  = in_valid && (rs_full[in_fu] || m_count == `ROB_SIZE);
        exp_disp   = in_valid && !exp_stall;
        // exactly the station of the accepted instruction
        exp_load   = '0;
        if (exp_disp)
            exp_load[in_fu] = 1'b1;
        exp_retire = (m_count != 0) && m_done[m_head];
        is_btu     = (in_fu == `FU_BTU);
        expect_operand(in_pc_valid && !is_btu, in_pc, in_src1, rdy1, val1);
        expect_operand(in_imm_valid && !is_btu && in_fu != `FU_LSU, in_imm, in_src2,
                       rdy2, val2);

        compare_value("stall", 32'(stall), 32'(exp_stall));
        compare_value("dispatch", 32'(dispatch), 32'(exp_disp));
        compare_value("rs_load", 32'(rs_load), 32'(exp_load));
        // next free slot, unchanged by a stall
        compare_value("rs_tag_dest", 32'(rs_tag_dest), 32'(m_tail));
        compare_value("rs_ready_src1", 32'(rs_ready_src1), 32'(rdy1));
        compare_value("rs_ready_src2", 32'(rs_ready_src2), 32'(rdy2));
        compare_value("rs_value_src1", rs_value_src1, val1);
        compare_value("rs_value_src2", rs_value_src2, val2);
        // waiting sources carry the producer tag
        if (!rdy1)
            compare_value("rs_tag_src1", 32'(rs_tag_src1), 32'(m_tag[in_src1]));
        if (!rdy2)
            compare_value("rs_tag_src2", 32'(rs_tag_src2), 32'(m_tag[in_src2]));
        compare_value("rs_imm", rs_imm, in_imm);
        compare_value("rs_pc", rs_pc, is_btu ? in_pc : 32'd0);
        compare_value("rs_npc", rs_npc, is_btu ? in_npc : 32'd0);
        compare_value("rs_fu_func", 32'(rs_fu_func), 32'(in_func));
        compare_value("rs_func3", 32'(rs_func3), 32'(in_func3));
        compare_value("commit_valid", 32'(commit_valid), 32'(exp_retire));
        if (exp_retire) begin
            compare_value("commit_reg", 32'(commit_reg), 32'(m_dest[m_head]));
            compare_value("commit_value", commit_value, m_val[m_head]);
        end
        if (exp_stall)
            t_stalls++;
    endtask

    // state after the coming rising edge
    task automatic update_model();
        logic               disp;
        logic               retire;
        ooo_pkg::rob_tag_t  ret_tag;
        ooo_pkg::reg_addr_t ret_dest;

        disp     = in_valid && !(rs_full[in_fu] || m_count == `ROB_SIZE);
        retire   = (m_count != 0) && m_done[m_head];
        ret_tag  = m_head;
        ret_dest = m_dest[m_head];
        held     = in_valid && !disp;
        // rename, then cdb promotion, then commit clear; x0 never renamed
        for (int r = 1; r < `REG_NUM; r++) begin
            if (disp && in_dest == ooo_pkg::reg_addr_t'(r)) begin
                m_tag[r]  = m_tail;
                m_stat[r] = `STAT_PENDING;
            end else if (cdb_valid && m_stat[r] == `STAT_PENDING && m_tag[r] == cdb_tag) begin
                m_stat[r] = `STAT_IN_ROB;
            end else if (retire && m_stat[r] != `STAT_REGFILE && m_tag[r] == ret_tag) begin
                m_stat[r] = `STAT_REGFILE;
            end
        end
        if (retire && ret_dest != '0)
            m_rf[ret_dest] = m_val[ret_tag];
        if (cdb_valid) begin
            m_val[cdb_tag]  = cdb_value;
            m_done[cdb_tag] = 1'b1;
        end
        if (disp) begin
            m_dest[m_tail] = in_dest;
            m_done[m_tail] = 1'b0;
            m_tail         = m_tail + 1'b1;
            m_count++;
        end
        if (retire) begin
            m_head = m_head + 1'b1;
            m_count--;
            t_commits++;
        end
    endtask

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    task automatic random_cycle(input int valid_pct, input int cdb_pct, input int full_pct,
                                input int ovr_pct, input int reg_span);
        ooo_pkg::rob_tag_t waiting [$];
        ooo_pkg::rob_tag_t t;

        @(negedge clk);
        if (!held) begin
            in_valid     = chance(valid_pct);
            in_fu        = ooo_pkg::fu_sel_t'($urandom % `FU_NUM);
            in_func      = ooo_pkg::func_t'($urandom);
            in_func3     = ooo_pkg::func3_t'($urandom);
            in_dest      = ooo_pkg::reg_addr_t'($urandom % reg_span);
            in_src1      = ooo_pkg::reg_addr_t'($urandom % reg_span);
            in_src2      = ooo_pkg::reg_addr_t'($urandom % reg_span);
            in_imm       = $urandom;
            in_pc        = $urandom;
            in_npc       = in_pc + 32'd4;
            in_imm_valid = chance(ovr_pct);
            in_pc_valid  = chance(ovr_pct);
        end
        for (int i = 0; i < `FU_NUM; i++)
            rs_full[i] = chance(full_pct);
        // cdb completes one outstanding, incomplete tag
        cdb_valid = 1'b0;
        if (chance(cdb_pct)) begin
            for (int k = 0; k < m_count; k++) begin
                t = ooo_pkg::rob_tag_t'(m_head + k);
                if (!m_done[t])
                    waiting.push_back(t);
            end
            if (waiting.size() > 0) begin
                cdb_valid = 1'b1;
                cdb_tag   = waiting[$urandom % waiting.size()];
                cdb_value = $urandom;
            end
        end
        // combinational outputs settle well before the rising edge
        #5;
        check_outputs();
        update_model();
    endtask

    task automatic start_test();
        t_errors  = 0;
        t_stalls  = 0;
        t_commits = 0;
        t_bypass  = 0;
    endtask

    task automatic report_test(input string name, input int cycles);
        tests_run++;
        $display("%s: cycles %0d, errors %0d, stalls %0d, commits %0d, bypasses %0d",
                 name, cycles, t_errors, t_stalls, t_commits, t_bypass);
    endtask

    task automatic run_test(input string name, input int cycles, input int valid_pct,
                            input int cdb_pct, input int full_pct, input int ovr_pct,
                            input int reg_span);
        start_test();
        repeat (cycles) random_cycle(valid_pct, cdb_pct, full_pct, ovr_pct, reg_span);
        report_test(name, cycles);
    endtask

    // watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog: the run exceeded its cycle budget of %0d cycles", WATCHDOG_CYCLES);
        $display("test failed");
        $finish;
    end

    initial begin
        int n;

        void'($urandom(SEED));
        total_errors = 0;
        total_checks = 0;
        tests_run    = 0;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_fu        = '0;
        in_func      = '0;
        in_func3     = '0;
        in_dest      = '0;
        in_src1      = '0;
        in_src2      = '0;
        in_imm       = '0;
        in_pc        = '0;
        in_npc       = '0;
        in_imm_valid = 1'b0;
        in_pc_valid  = 1'b0;
        rs_full      = '0;
        cdb_valid    = 1'b0;
        cdb_tag      = '0;
        cdb_value    = '0;
        reset_model();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        run_test("reset_idle", CYC_IDLE, 0, 0, 0, 0, 32);
        run_test("station_full", CYC_STATION, 100, 40, 50, 20, 32);
        // no cdb, so the rob fills up and stalls
        run_test("rob_full", CYC_ROB, 100, 0, 0, 0, 32);
        // few registers, many dependencies and bypass hits
        run_test("dependency", CYC_DEPEND, 80, 60, 10, 10, 4);
        run_test("override", CYC_OVERRIDE, 80, 50, 10, 80, 4);
        run_test("random_mix", CYC_RANDOM, 70, 50, 10, 30, 32);

        // complete everything and let it retire
        start_test();
        n = 0;
        while ((m_count != 0 || held) && n < CYC_DRAIN) begin
            random_cycle(0, 100, 0, 0, 32);
            n++;
        end
        if (m_count != 0 || held) begin
            $display("drain: %0d ROB entries still outstanding after %0d cycles", m_count, n);
            t_errors++;
            total_errors++;
        end
        report_test("drain", n);

        $display("summary: %0d tests, %0d checks, %0d errors", tests_run, total_checks,
                 total_errors);
        if (total_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+source
source/ooo_pkg.sv
source/ooo_ifs.sv
source/map_table.sv
source/reorder_buffer.sv
source/arch_regfile.sv
source/dispatcher.sv
source/dispatch_top.sv
tb/dispatch_sva.sv
tb/dispatch_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the dispatch stage testbench with verilator and runs it
# the result comes from the simulation log

set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module dispatch_tb \
    -f src.f \
    -o dispatch_sim

./obj_dir/dispatch_sim | tee sim.log

if grep -q "test failed" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi

echo "simulation finished clean, see sim.log"
